// ==== Makefile ====
TOP := tb_tpu_cfu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f tpu_cfu.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== testbench/tb_tpu_cfu.sv ====
// ##############################
// Testbench for the TPU custom unit
// Drives commands over the handshake,
// keeps a model of A, B and the lanes
// and checks responses with assertions
// ##############################

`timescale 1ns/1ps

module tb_tpu_cfu;

  localparam logic [6:0] OP_WA  = 7'd1;
  localparam logic [6:0] OP_WB  = 7'd2;
  localparam logic [6:0] OP_CMP = 7'd3;
  localparam logic [6:0] OP_RD  = 7'd4;
  localparam int CMD_TIMEOUT = 50;
  localparam int RSP_TIMEOUT = 2000;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_outputs_0;

  // Model state
  logic [7:0]  model_a [256];
  logic [31:0] model_b [256];
  logic [31:0] exp_lanes [4];
  logic [31:0] exp_rsp;

  int  errors;
  int  tests_run;
  int  passed;
  int  err_mark;
  bit  timed_out;

  tpu_cfu tpu_cfu_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Held response must not move
  rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_outputs_0))
  else begin
    $display("Response dropped or changed while rsp_ready was low");
    errors = errors + 1;
  end

  ready_low: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !cmd_ready)
  else begin
    $display("cmd_ready was high while a response was pending");
    errors = errors + 1;
  end

  rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp_outputs_0 == exp_rsp)
  else begin
    $display("FAILED rsp_outputs_0: got %h, expected %h",
             $sampled(rsp_outputs_0), $sampled(exp_rsp));
    errors = errors + 1;
  end

  // Everything but compute answers on the next edge
  quick_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready && cmd_function_id[9:3] != OP_CMP |=> rsp_valid)
  else begin
    $display("No response one cycle after a write, read or unknown command");
    errors = errors + 1;
  end

  task automatic do_command(input logic [6:0] op, input logic [31:0] in0,
                            input logic [31:0] in1, input logic [31:0] expected,
                            input bit stall);
    int cnt;
    int hold;
    logic [2:0] funct3;
    if (timed_out) return;
    cnt = 0;
    while (!cmd_ready && !timed_out) begin
      if (cnt == CMD_TIMEOUT) begin
        $display("Timeout: cmd_ready stayed low for %0d cycles", CMD_TIMEOUT);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        cnt++;
      end
    end
    if (timed_out) return;
    funct3 = 3'($urandom_range(0, 7));
    exp_rsp = expected;
    cmd_valid = 1'b1;
    cmd_function_id = {op, funct3};
    cmd_inputs_0 = in0;
    cmd_inputs_1 = in1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    hold = stall ? $urandom_range(1, 6) : 0;
    rsp_ready = (hold == 0);
    cnt = 0;
    while (!(rsp_valid && rsp_ready) && !timed_out) begin
      if (cnt == RSP_TIMEOUT) begin
        $display("Timeout: no response within %0d cycles", RSP_TIMEOUT);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        cnt++;
        if (rsp_valid && hold > 0) hold--;
        rsp_ready = (hold == 0);
      end
    end
    if (timed_out) return;
    @(posedge clk);
    #1;
    rsp_ready = 1'b0;
  endtask

  task automatic write_a(input int addr, input logic [7:0] val, input bit stall);
    model_a[addr] = val;
    do_command(OP_WA, 32'(addr), {val, 24'h0}, 32'h0, stall);
  endtask

  task automatic write_b(input int addr, input logic [31:0] word, input bit stall);
    model_b[addr] = word;
    do_command(OP_WB, 32'(addr), word, 32'h0, stall);
  endtask

  // Lane j sums A[i] times byte 3-j of B[i]
  task automatic compute(input int k, input bit stall);
    int sum;
    logic signed [7:0] av;
    logic signed [7:0] bv;
    for (int j = 0; j < 4; j++) begin
      sum = 0;
      for (int i = 0; i < k; i++) begin
        av = model_a[i];
        bv = model_b[i][8*(3-j) +: 8];
        sum = sum + int'(av) * int'(bv);
      end
      exp_lanes[j] = 32'(sum);
    end
    do_command(OP_CMP, 32'(k), 32'h0, 32'h0, stall);
  endtask

  task automatic read_lanes(input bit stall);
    for (int j = 0; j < 4; j++) begin
      do_command(OP_RD, 32'h0, 32'(j), exp_lanes[j], stall);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark && !timed_out) begin
      passed++;
      $display("Test %0d (%s): passed", tests_run, name);
    end else begin
      $display("Test %0d (%s): failed", tests_run, name);
    end
    err_mark = errors;
  endtask

  initial begin
    void'($urandom(32'h7056));
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0 = '0;
    cmd_inputs_1 = '0;
    rsp_ready = 1'b0;
    exp_rsp = '0;
    errors = 0;
    tests_run = 0;
    passed = 0;
    err_mark = 0;
    timed_out = 1'b0;
    for (int j = 0; j < 4; j++) exp_lanes[j] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    reset_state: assert (!rsp_valid && cmd_ready)
    else begin
      $display("FAILED rsp_valid/cmd_ready after reset: %h/%h, expected 0/1",
               rsp_valid, cmd_ready);
      errors = errors + 1;
    end
    read_lanes(1'b0);
    end_test("reset state and zero lanes");

    // Signed corner values, -128 included
    write_a(0, 8'h80, 1'b0);
    write_a(1, 8'h7f, 1'b0);
    write_a(2, 8'hff, 1'b0);
    write_a(3, 8'h05, 1'b0);
    write_b(0, 32'h807f01ff, 1'b0);
    write_b(1, 32'h8080027f, 1'b0);
    write_b(2, 32'h03fe8010, 1'b0);
    write_b(3, 32'hff0040c0, 1'b0);
    compute(4, 1'b0);
    read_lanes(1'b0);
    end_test("writes and K=4 signed product");

    for (int i = 0; i < 256; i++) begin
      write_a(i, 8'($urandom()), 1'b0);
      write_b(i, $urandom(), 1'b0);
    end
    compute(256, 1'b0);
    read_lanes(1'b0);
    end_test("K=256 random operands");

    read_lanes(1'b1);
    write_a(5, 8'($urandom()), 1'b1);
    compute(8, 1'b1);
    read_lanes(1'b1);
    end_test("response held under rsp_ready stalls");

    do_command(7'h55, $urandom(), $urandom(), 32'h0, 1'b0);
    do_command(7'h00, $urandom(), $urandom(), 32'h0, 1'b0);
    compute(0, 1'b0);
    read_lanes(1'b0);
    compute(4, 1'b0);
    for (int i = 0; i < 4; i++) begin
      write_a(i, 8'($urandom()), 1'b0);
      write_b(i, $urandom(), 1'b0);
    end
    read_lanes(1'b0);
    end_test("unknown opcode, K=0 and result retention");

    $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             tests_run, passed, tests_run - passed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tpu_cfu.f ====
verilog/tpu_pkg.sv
verilog/tpu_ctrl_if.sv
verilog/operand_buffer.sv
verilog/mac_pe.sv
verilog/result_store.sv
verilog/matmul_engine.sv
verilog/cmd_sequencer.sv
verilog/tpu_cfu.sv
testbench/tb_tpu_cfu.sv

// ==== verilog/cmd_sequencer.sv ====
// ##############################
// Command sequencer
// Decodes CPU commands, drives buffer
// writes and compute start, and holds
// the response until it is taken
// ##############################

`timescale 1ns/1ps

module cmd_sequencer
  import tpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic [9:0]        cmd_function_id,
  input  logic [31:0]       cmd_inputs_0,
  input  logic [31:0]       cmd_inputs_1,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [31:0]       rsp_outputs_0,
  output logic              a_wr_en,
  output logic              b_wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [ELEM_W-1:0] a_wr_data,
  output logic [31:0]       b_wr_data,
  tpu_ctrl_if.seq           ctrl
);

  seq_state_e  state_q;
  seq_state_e  state_d;
  opcode_e     opcode;
  logic        accept;
  logic [31:0] rsp_data_q;

  assign opcode    = opcode_e'(cmd_function_id[9:3]);
  assign cmd_ready = (state_q == S_IDLE);
  assign accept    = cmd_valid && cmd_ready;

  // Buffer writes land on the acceptance edge
  assign a_wr_en   = accept && (opcode == OP_WRITE_A);
  assign b_wr_en   = accept && (opcode == OP_WRITE_B);
  assign wr_addr   = cmd_inputs_0[ADDR_W-1:0];
  assign a_wr_data = cmd_inputs_1[31:24];
  assign b_wr_data = cmd_inputs_1;

  assign ctrl.start = accept && (opcode == OP_COMPUTE);
  assign ctrl.k_len = cmd_inputs_0[K_W-1:0];
  assign ctrl.lane  = cmd_inputs_1[LANE_W-1:0];

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          state_d = (opcode == OP_COMPUTE) ? S_BUSY : S_RESP;
        end
      end
      S_BUSY: begin
        if (ctrl.done) begin
          state_d = S_RESP;
        end
      end
      S_RESP: begin
        if (rsp_ready) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Only a read returns data, everything else answers 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_data_q <= '0;
    end else if (accept) begin
      rsp_data_q <= (opcode == OP_READ) ? ctrl.lane_value : '0;
    end
  end

  assign rsp_valid     = (state_q == S_RESP);
  assign rsp_outputs_0 = rsp_data_q;

  // A pending response must not change before the CPU takes it
  property p_rsp_hold;
    @(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_outputs_0);
  endproperty
  a_rsp_hold: assert property (p_rsp_hold);

endmodule

// ==== verilog/mac_pe.sv ====
// ##############################
// MAC processing element
// Signed multiply-accumulate that
// passes its A operand to the east
// ##############################

`timescale 1ns/1ps

module mac_pe
  import tpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic [ELEM_W-1:0] a_in,
  input  logic [ELEM_W-1:0] b_in,
  output logic [ELEM_W-1:0] a_out,
  output logic [ACC_W-1:0]  acc
);

  logic signed [2*ELEM_W-1:0] prod;
  logic signed [ACC_W-1:0]    acc_q;
  logic [ELEM_W-1:0]          a_q;

  assign prod = $signed(a_in) * $signed(b_in);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      a_q   <= '0;
    end else begin
      a_q <= a_in;
      // Sum wraps at the accumulator width
      if (clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + prod;
      end
    end
  end

  assign a_out = a_q;
  assign acc   = acc_q;

endmodule

// ==== verilog/matmul_engine.sv ====
// ##############################
// Matrix row engine
// Streams K operands from the buffers
// through a skewed row of MAC PEs
// and signals when sums are final
// ##############################

`timescale 1ns/1ps

module matmul_engine
  import tpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ELEM_W-1:0] a_rd_data,
  input  logic [31:0]       b_rd_data,
  output logic [ADDR_W-1:0] rd_addr,
  output acc_lanes_t        lanes,
  tpu_ctrl_if.engine        ctrl
);

  eng_state_e        state_q;
  logic [K_W-1:0]    k_q;
  logic [K_W-1:0]    issue_cnt;
  logic [LANE_W:0]   drain_cnt;
  logic              data_valid_q;
  logic [ELEM_W-1:0] a_gated;
  logic [ELEM_W-1:0] b_col [LANES];
  logic [ELEM_W-1:0] b_skew [LANES];
  logic [ELEM_W-1:0] a_chain [LANES+1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= E_IDLE;
      k_q       <= '0;
      issue_cnt <= '0;
      drain_cnt <= '0;
    end else begin
      case (state_q)
        E_IDLE: begin
          if (ctrl.start) begin
            k_q       <= ctrl.k_len;
            issue_cnt <= '0;
            drain_cnt <= '0;
            // K of zero skips straight to the drain wait
            state_q   <= (ctrl.k_len == '0) ? E_DRAIN : E_FEED;
          end
        end
        E_FEED: begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == k_q - K_W'(1)) begin
            state_q <= E_DRAIN;
          end
        end
        E_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == (LANE_W+1)'(LANES)) begin
            state_q <= E_IDLE;
          end
        end
        default: state_q <= E_IDLE;
      endcase
    end
  end

  assign rd_addr   = issue_cnt[ADDR_W-1:0];
  // Skew of LANES-1 plus one cycle of read latency has elapsed
  assign ctrl.done = (state_q == E_DRAIN) && (drain_cnt == (LANE_W+1)'(LANES));

  // Read data is valid the cycle after an address is issued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_valid_q <= 1'b0;
    end else begin
      data_valid_q <= (state_q == E_FEED);
    end
  end

  assign a_gated    = data_valid_q ? a_rd_data : '0;
  assign a_chain[0] = a_gated;

  for (genvar j = 0; j < LANES; j++) begin : g_col
    // Column 0 sits in the top byte
    assign b_col[j] = data_valid_q ? b_rd_data[ELEM_W*(LANES-1-j) +: ELEM_W] : '0;

    if (j == 0) begin : g_direct
      assign b_skew[j] = b_col[j];
    end else begin : g_delay
      logic [ELEM_W-1:0] dly_q [j];

      // j stages to line B up with A on the forwarding chain
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          dly_q <= '{default: '0};
        end else begin
          dly_q[0] <= b_col[j];
          for (int s = 1; s < j; s++) begin
            dly_q[s] <= dly_q[s-1];
          end
        end
      end

      assign b_skew[j] = dly_q[j-1];
    end

    mac_pe u_pe (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (ctrl.start),
      .a_in  (a_chain[j]),
      .b_in  (b_skew[j]),
      .a_out (a_chain[j+1]),
      .acc   (lanes[j])
    );
  end

  a_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n) ctrl.start |-> state_q == E_IDLE
  );

endmodule

// ==== verilog/operand_buffer.sv ====
// ##############################
// Operand buffer
// Simple dual-port memory with one
// write port and a registered read
// ##############################

`timescale 1ns/1ps

module operand_buffer
  import tpu_pkg::*;
#(
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data shows up one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== verilog/result_store.sv ====
// ##############################
// Result store
// Holds the four lane sums of the
// last compute and picks one to read
// ##############################

`timescale 1ns/1ps

module result_store
  import tpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  acc_lanes_t lanes,
  tpu_ctrl_if.store  ctrl
);

  acc_lanes_t lanes_q;

  // Capture on the engine's done pulse only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lanes_q <= '0;
    end else if (ctrl.done) begin
      lanes_q <= lanes;
    end
  end

  assign ctrl.lane_value = lanes_q[ctrl.lane];

endmodule

// ==== verilog/tpu_cfu.sv ====
// ##############################
// TPU custom function unit top
// Row matrix-product accelerator
// behind a command/response handshake
// ##############################

`timescale 1ns/1ps

module tpu_cfu
  import tpu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_outputs_0
);

  logic              a_wr_en;
  logic              b_wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [ELEM_W-1:0] a_wr_data;
  logic [31:0]       b_wr_data;
  logic [ADDR_W-1:0] rd_addr;
  logic [ELEM_W-1:0] a_rd_data;
  logic [31:0]       b_rd_data;
  acc_lanes_t        lanes;

  tpu_ctrl_if ctrl ();

  cmd_sequencer u_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0),
    .a_wr_en         (a_wr_en),
    .b_wr_en         (b_wr_en),
    .wr_addr         (wr_addr),
    .a_wr_data       (a_wr_data),
    .b_wr_data       (b_wr_data),
    .ctrl            (ctrl.seq)
  );

  // Vector A, one element per entry
  operand_buffer #(.DATA_W(ELEM_W)) buf_a (
    .clk     (clk),
    .wr_en   (a_wr_en),
    .wr_addr (wr_addr),
    .wr_data (a_wr_data),
    .rd_addr (rd_addr),
    .rd_data (a_rd_data)
  );

  // Matrix B, four packed columns per entry
  operand_buffer #(.DATA_W(32)) buf_b (
    .clk     (clk),
    .wr_en   (b_wr_en),
    .wr_addr (wr_addr),
    .wr_data (b_wr_data),
    .rd_addr (rd_addr),
    .rd_data (b_rd_data)
  );

  matmul_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_rd_data (a_rd_data),
    .b_rd_data (b_rd_data),
    .rd_addr   (rd_addr),
    .lanes     (lanes),
    .ctrl      (ctrl.engine)
  );

  result_store u_store (
    .clk   (clk),
    .rst_n (rst_n),
    .lanes (lanes),
    .ctrl  (ctrl.store)
  );

endmodule

// ==== verilog/tpu_ctrl_if.sv ====
// ##############################
// Control interface between the
// sequencer, engine and result store
// ##############################

`timescale 1ns/1ps

interface tpu_ctrl_if import tpu_pkg::*; ();

  logic             start;
  logic [K_W-1:0]   k_len;
  logic             done;
  logic [LANE_W-1:0] lane;
  logic [ACC_W-1:0] lane_value;

  modport seq    (output start, output k_len, output lane,
                  input done, input lane_value);

  modport engine (input start, input k_len, output done);

  modport store  (input done, input lane, output lane_value);

endinterface

// ==== verilog/tpu_pkg.sv ====
// ##############################
// TPU custom instruction package
// Sizes, command opcodes, FSM state
// encodings and the lane array type
// ##############################

package tpu_pkg;

  // Operand buffer and command field sizes
  localparam int ADDR_W   = 8;
  localparam int K_W      = 9;
  localparam int ELEM_W   = 8;
  localparam int ACC_W    = 32;
  localparam int LANES    = 4;
  localparam int LANE_W   = 2;
  localparam int FUNCT7_W = 7;

  // Taken from function_id[9:3]
  typedef enum logic [FUNCT7_W-1:0] {
    OP_WRITE_A = 7'd1,
    OP_WRITE_B = 7'd2,
    OP_COMPUTE = 7'd3,
    OP_READ    = 7'd4
  } opcode_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_RESP
  } seq_state_e;

  typedef enum logic [1:0] {
    E_IDLE,
    E_FEED,
    E_DRAIN
  } eng_state_e;

  // One accumulator word per PE column
  typedef logic [LANES-1:0][ACC_W-1:0] acc_lanes_t;

endpackage
